// ==== include/txdma_settings.svh ====
/*
 * Transmit DMA build settings
 * Bus and frame widths, ring index width, word counter width,
 * FIFO depth, read-pause margin and the fill level that starts sending
 */
`ifndef TXDMA_SETTINGS_SVH
`define TXDMA_SETTINGS_SVH

// Bus and frame widths
`define TXDMA_DATA_W       32   // Memory word width
`define TXDMA_LEN_W        16   // Frame length field
`define TXDMA_IDX_W        7    // Descriptor ring index
`define TXDMA_CNT_W        14   // Word counters, LEN_W - 2

// Data FIFO sizing
`define TXDMA_FIFO_DEPTH   32   // Entries
`define TXDMA_FIFO_MARGIN  5    // Cushion below full where reads pause
`define TXDMA_START_LEVEL  8    // Fill level that lets the streamer start

`endif

// ==== hw/txdma_pkg.sv ====
/*
 * Transmit DMA shared types
 * Descriptor and status words, FIFO entry, controller states,
 * FIFO fill level and the status error rule
 */
`include "txdma_settings.svh"

package txdma_pkg;

    // MAC status, also the low 9 bits of a descriptor
    typedef struct packed {
        logic       underrun;           // Buffer underrun
        logic [3:0] retry_cnt;          // Retries before success
        logic       rl;                 // Retransmission limit
        logic       lc;                 // Late collision
        logic       df;                 // Deferred
        logic       cs;                 // Carrier sense lost
    } tx_stat_t;

    typedef struct packed {
        logic [`TXDMA_LEN_W-1:0] len;   // Frame length in bytes
        logic       ready;              // Owned by the DMA
        logic       irq;                // Interrupt when done
        logic       wrap;               // Last descriptor of the ring
        logic       pad;                // Pad short frames
        logic       crc;                // Append CRC
        logic [1:0] rsvd;
        tx_stat_t   stat;
    } tx_desc_t;

    typedef struct packed {
        logic       first;              // First word of the frame
        logic       last;               // Last word of the frame
        logic [1:0] valid_cnt;          // Valid bytes minus one
        logic [`TXDMA_DATA_W-1:0] data;
    } fifo_word_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_READ, ST_DRAIN, ST_STAT, ST_WB
    } ctrl_state_t;

    typedef logic [$clog2(`TXDMA_FIFO_DEPTH+1)-1:0] fifo_lvl_t;

    // Retry count alone is not an error
    function automatic logic stat_error(tx_stat_t s);
        return s.underrun | s.rl | s.lc | s.df | s.cs;
    endfunction

endpackage

// ==== hw/txdma_word_fifo.sv ====
/*
 * Synchronous FIFO of transmit words
 * Show-ahead output, fill count and synchronous clear
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module txdma_word_fifo
    import txdma_pkg::*;
#(
    parameter int DEPTH = `TXDMA_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,                   // Flush all entries
    input  logic       write,
    input  fifo_word_t din,
    input  logic       read,                    // Pop the head entry
    output fifo_word_t dout,                    // Head entry, valid when not empty
    output logic       empty,
    output logic       full,
    output logic [$clog2(DEPTH+1)-1:0] level
);

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(DEPTH + 1);

    fifo_word_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    assign dout  = mem[rd_ptr];                 // Show-ahead
    assign empty = (level == '0);
    assign full  = (level == LW'(DEPTH));

    always_ff @(posedge clk) begin
        if (write) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (write) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (read)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({write, read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;        // Both or neither
            endcase
        end
    end

    // Reader pauses early enough to never overrun
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        write && !clear |-> !full);

    // Streamer only pops what is there
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        read && !clear |-> !empty);

endmodule

// ==== hw/txdma_desc_ctrl.sv ====
/*
 * Transmit descriptor controller
 * Six-state FSM over the descriptor ring, descriptor and pointer
 * registers, write-back word, ring index and interrupts
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module txdma_desc_ctrl
    import txdma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_en,                  // Transmit enable
    input  logic [`TXDMA_IDX_W-1:0] max_tx_bd,  // Highest ring index
    input  tx_desc_t    bd_desc,
    input  logic [31:0] bd_ptr,                 // Frame buffer byte address
    input  logic        bd_wait,                // Descriptor RAM busy
    output logic        bd_read,
    output logic        bd_write,
    output logic [`TXDMA_IDX_W-1:0] bd_index,
    output tx_desc_t    bd_writedata,
    input  logic        reads_done,             // Reader finished or drained
    input  logic        stat_ready,             // Streamer holds a status
    input  tx_stat_t    stat,
    input  logic        tx_retry,               // Send the same frame again
    output ctrl_state_t state,
    output logic        load,                   // First cycle of ST_READ
    output logic [31:0] ptr,
    output logic [`TXDMA_LEN_W-1:0] len,
    output logic        stat_done,              // Status consumed
    output logic        per_packet_pad,
    output logic        per_packet_crc,
    output logic        txb_irq,
    output logic        txe_irq
);

    tx_desc_t    desc;                          // Registered descriptor
    logic [31:0] bd_ptr_r;                      // Registered buffer pointer
    logic        fetch_ok;                      // Ready descriptor arrives
    logic        wb_done;                       // Write-back accepted

    assign fetch_ok = (state == ST_FETCH) & ~bd_wait & bd_desc.ready;
    assign wb_done  = (state == ST_WB) & ~bd_wait;

    assign bd_read  = (state == ST_FETCH);
    assign bd_write = (state == ST_WB);

    always_comb begin
        bd_writedata       = desc;
        bd_writedata.ready = 1'b0;              // Hand back to software
        bd_writedata.stat  = stat;
    end

    assign ptr            = bd_ptr_r;
    assign len            = desc.len;
    assign per_packet_pad = desc.pad;
    assign per_packet_crc = desc.crc;

    // Retry skips write-back, status still gets released
    assign stat_done = wb_done | ((state == ST_STAT) & stat_ready & tx_retry);

    //*********************************************************************
    // Main FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (tx_en & ~stat_ready) state <= ST_FETCH;
                ST_FETCH: if (~bd_wait) state <= bd_desc.ready ? ST_READ : ST_IDLE;
                ST_READ: begin
                    if (reads_done)      state <= ST_STAT;
                    else if (stat_ready) state <= ST_DRAIN;     // MAC ended early
                end
                ST_DRAIN: if (reads_done) state <= ST_STAT;     // Pending reads landed
                ST_STAT:  if (stat_ready) state <= tx_retry ? ST_IDLE : ST_WB;
                ST_WB:    if (~bd_wait) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ok) begin
            desc     <= bd_desc;
            bd_ptr_r <= bd_ptr;
        end
    end

    //*********************************************************************
    // Ring index, load strobe and interrupts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bd_index <= '0;
            load     <= 1'b0;
            txb_irq  <= 1'b0;
            txe_irq  <= 1'b0;
        end else begin
            load    <= fetch_ok;
            txb_irq <= wb_done & desc.irq & ~stat_error(stat);
            txe_irq <= wb_done & desc.irq & stat_error(stat);
            if (wb_done) begin
                if (desc.wrap | (bd_index == max_tx_bd)) bd_index <= '0;
                else                                     bd_index <= bd_index + 1'b1;
            end else if ((state == ST_IDLE) & ~tx_en) begin
                bd_index <= '0;                 // Restart the ring when disabled
            end
        end
    end

    a_bd_excl: assert property (@(posedge clk) disable iff (reset)
        !(bd_read && bd_write));

endmodule

// ==== hw/txdma_mem_reader.sv ====
/*
 * Frame buffer reader
 * Word count from length and offset, registered memory reads,
 * issue and receive counters, FIFO protection and word packing
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module txdma_mem_reader
    import txdma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ctrl_state_t state,
    input  logic        load,                   // New frame parameters valid
    input  logic [31:0] ptr,
    input  logic [`TXDMA_LEN_W-1:0] len,
    input  logic        av_waitrequest,
    input  logic [`TXDMA_DATA_W-1:0] av_readdata,
    input  logic        av_readdatavalid,
    output logic        av_read,
    output logic [31:0] av_address,
    input  fifo_lvl_t   fifo_level,
    output logic        fifo_write,
    output fifo_word_t  fifo_din,
    output logic        reads_done              // Last word packed, or drain over
);

    localparam int LW        = `TXDMA_LEN_W;
    localparam int CW        = `TXDMA_CNT_W;
    localparam int THRESHOLD = `TXDMA_FIFO_DEPTH - `TXDMA_FIFO_MARGIN;

    logic [LW-1:0] tg_bytes;                    // len + offset + 3
    logic [CW-1:0] tg_cnt;                      // Words to read
    logic [CW-1:0] rd_cnt;                      // Reads issued
    logic [CW-1:0] wr_cnt;                      // Words written to FIFO
    logic [CW-1:0] pending;
    logic [CW:0]   committed;                   // FIFO fill once reads land
    logic [29:0]   word_addr;
    logic [1:0]    off;                         // Buffer byte offset
    logic [1:0]    len_lo;
    logic          pre_read;
    logic          issue;
    logic          hold;                        // FIFO protection pause
    logic [`TXDMA_DATA_W-1:0] rdata;
    logic          valid_rdata;
    logic          first_word;
    logic          last_word;

    assign tg_bytes  = len + LW'(ptr[1:0]) + LW'(3);
    assign pre_read  = (state == ST_READ) & ~load & ~hold & (rd_cnt != tg_cnt);
    assign issue     = pre_read & ~av_waitrequest;      // Enters the request register
    assign pending   = rd_cnt - wr_cnt;
    assign committed = (CW+1)'(fifo_level) + (CW+1)'(pending);

    //*********************************************************************
    // Request stage and counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            av_read     <= 1'b0;
            rd_cnt      <= '0;
            wr_cnt      <= '0;
            hold        <= 1'b0;
            valid_rdata <= 1'b0;
        end else begin
            if (~av_waitrequest) av_read <= pre_read;
            valid_rdata <= av_readdatavalid;
            hold        <= committed > (CW+1)'(THRESHOLD);  // One cycle behind
            if (load) begin
                rd_cnt <= '0;
                wr_cnt <= '0;
            end else begin
                if (issue)       rd_cnt <= rd_cnt + 1'b1;
                if (valid_rdata) wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= av_readdata;
        if (~av_waitrequest) av_address <= {word_addr, 2'b00};
        if (load) begin
            word_addr <= ptr[31:2];
            off       <= ptr[1:0];
            len_lo    <= len[1:0];
            tg_cnt    <= tg_bytes[LW-1:2];
        end else if (issue) begin
            word_addr <= word_addr + 1'b1;
        end
    end

    //*********************************************************************
    // Word packing
    assign first_word = (wr_cnt == '0);
    assign last_word  = ((wr_cnt + 1'b1) == tg_cnt);
    assign fifo_write = valid_rdata;

    always_comb begin
        fifo_din.first = first_word;
        fifo_din.last  = last_word;
        fifo_din.data  = first_word ? (rdata >> {off, 3'b000}) : rdata;
        case ({first_word, last_word})
            2'b11:   fifo_din.valid_cnt = len_lo - 2'd1;        // Whole frame in one word
            2'b10:   fifo_din.valid_cnt = 2'd3 - off;
            2'b01:   fifo_din.valid_cnt = len_lo + off - 2'd1;
            default: fifo_din.valid_cnt = 2'd3;
        endcase
    end

    assign reads_done = (valid_rdata & last_word) |
                        ((state == ST_DRAIN) & ~av_read & (rd_cnt == wr_cnt));

    // Data only comes back for an accepted, unanswered read
    a_no_stray_data: assert property (@(posedge clk) disable iff (reset)
        av_readdatavalid |-> (pending > CW'(valid_rdata) + CW'(av_read)));

endmodule

// ==== hw/txdma_byte_streamer.sv ====
/*
 * Byte streamer toward the MAC
 * Send FSM, byte select, frame markers, FIFO flush,
 * status capture and underrun flag
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module txdma_byte_streamer
    import txdma_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  fifo_lvl_t  level,
    input  logic       reads_done,
    input  fifo_word_t fifo_dout,
    input  logic       fifo_empty,
    output logic       fifo_read,
    output logic [7:0] tx_data,
    output logic       tx_dv,
    output logic       tx_sop,
    output logic       tx_eop,
    input  logic       tx_ack,                  // MAC takes the current byte
    input  tx_stat_t   tx_stat,
    input  logic       tx_stat_valid,
    output logic       stat_ready,              // Held until stat_done
    output tx_stat_t   stat,
    input  logic       stat_done,
    output logic       tx_underrun
);

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_WAIT} tx_state_t;

    tx_state_t  tx_state;
    logic [1:0] byte_idx;
    logic       last_byte;                      // Last valid byte of the head word
    logic       frame_end;
    logic       start;

    assign start     = (level >= fifo_lvl_t'(`TXDMA_START_LEVEL)) | reads_done;
    assign last_byte = (byte_idx == fifo_dout.valid_cnt);
    assign frame_end = tx_ack & ~fifo_empty & last_byte & fifo_dout.last;

    assign tx_data     = fifo_dout.data[byte_idx*8 +: 8];
    assign tx_dv       = (tx_state == TX_SEND);
    assign tx_sop      = tx_dv & (byte_idx == 2'd0) & fifo_dout.first;
    assign tx_eop      = tx_dv & last_byte & fifo_dout.last;
    assign tx_underrun = tx_dv & tx_ack & fifo_empty;

    // Pop after the last byte, flush everything left while waiting
    assign fifo_read = ~fifo_empty &
                       (((tx_state == TX_SEND) & last_byte & tx_ack) | (tx_state == TX_WAIT));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_state   <= TX_IDLE;
            byte_idx   <= 2'd0;
            stat_ready <= 1'b0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    byte_idx <= 2'd0;
                    if (start) tx_state <= TX_SEND;
                end
                TX_SEND: begin
                    if (tx_ack & ~fifo_empty) byte_idx <= last_byte ? 2'd0 : byte_idx + 1'b1;
                    if (frame_end | tx_stat_valid) tx_state <= TX_WAIT;  // Early status aborts
                end
                TX_WAIT: if (stat_done) tx_state <= TX_IDLE;
                default: tx_state <= TX_IDLE;
            endcase
            if (stat_done)
                stat_ready <= 1'b0;
            else if (tx_stat_valid & (tx_state != TX_IDLE))
                stat_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_stat_valid) stat <= tx_stat;
    end

endmodule

// ==== hw/txdma_top.sv ====
/*
 * Transmit DMA top level
 * Descriptor controller, memory reader, word FIFO and byte streamer
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module txdma_top
    import txdma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_en,
    input  logic [`TXDMA_IDX_W-1:0] max_tx_bd,
    // Descriptor RAM
    input  tx_desc_t    bd_desc,
    input  logic [31:0] bd_ptr,
    input  logic        bd_wait,
    output logic        bd_read,
    output logic        bd_write,
    output logic [`TXDMA_IDX_W-1:0] bd_index,
    output tx_desc_t    bd_writedata,
    // Memory
    input  logic        av_waitrequest,
    input  logic [`TXDMA_DATA_W-1:0] av_readdata,
    input  logic        av_readdatavalid,
    output logic        av_read,
    output logic [31:0] av_address,
    // MAC
    output logic [7:0]  tx_data,
    output logic        tx_dv,
    output logic        tx_sop,
    output logic        tx_eop,
    input  logic        tx_ack,
    input  tx_stat_t    tx_stat,
    input  logic        tx_stat_valid,
    input  logic        tx_retry,
    output logic        per_packet_pad,
    output logic        per_packet_crc,
    output logic        tx_underrun,
    output logic        txb_irq,
    output logic        txe_irq
);

    ctrl_state_t state;
    logic        load;
    logic [31:0] ptr;
    logic [`TXDMA_LEN_W-1:0] len;
    logic        reads_done;
    logic        stat_ready;
    logic        stat_done;
    tx_stat_t    stat;
    logic        fifo_write;
    logic        fifo_read;
    logic        fifo_empty;
    fifo_word_t  fifo_din;
    fifo_word_t  fifo_dout;
    fifo_lvl_t   fifo_level;

    txdma_desc_ctrl ctrl_i (
        .clk, .reset, .tx_en, .max_tx_bd,
        .bd_desc, .bd_ptr, .bd_wait, .bd_read, .bd_write, .bd_index, .bd_writedata,
        .reads_done, .stat_ready, .stat, .tx_retry,
        .state, .load, .ptr, .len, .stat_done,
        .per_packet_pad, .per_packet_crc, .txb_irq, .txe_irq
    );

    txdma_mem_reader reader_i (
        .clk, .reset, .state, .load, .ptr, .len,
        .av_waitrequest, .av_readdata, .av_readdatavalid, .av_read, .av_address,
        .fifo_level, .fifo_write, .fifo_din, .reads_done
    );

    txdma_word_fifo #(.DEPTH(`TXDMA_FIFO_DEPTH)) fifo_i (
        .clk, .reset,
        .clear (state == ST_IDLE),              // Drop leftovers between frames
        .write (fifo_write),
        .din   (fifo_din),
        .read  (fifo_read),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  (),
        .level (fifo_level)
    );

    txdma_byte_streamer streamer_i (
        .clk, .reset,
        .level (fifo_level),
        .reads_done, .fifo_dout, .fifo_empty, .fifo_read,
        .tx_data, .tx_dv, .tx_sop, .tx_eop, .tx_ack, .tx_stat, .tx_stat_valid,
        .stat_ready, .stat, .stat_done, .tx_underrun
    );

endmodule

// ==== verification/tb_txdma.sv ====
/*
 * Transmit DMA testbench
 * Clock and reset, memory and descriptor RAM models, MAC model,
 * directed frame tests, watchdog and closing report
 */
`timescale 1ns/1ps
`include "txdma_settings.svh"

module tb_txdma
    import txdma_pkg::*;
;

    localparam int CLK_PERIOD  = 100;
    localparam int TOTAL_BYTES = 8 + 13 + 2*16 + 3*8 + 2*4 + 200 + 2*20;
    localparam int WD_CYCLES   = TOTAL_BYTES * 20 + 3000;   // Bytes plus fetch and setup slack

    logic        clk = 1'b0;
    logic        reset;
    logic        tx_en;
    logic [`TXDMA_IDX_W-1:0] max_tx_bd;
    tx_desc_t    bd_desc;
    logic [31:0] bd_ptr;
    logic        bd_wait;
    logic        bd_read;
    logic        bd_write;
    logic [`TXDMA_IDX_W-1:0] bd_index;
    tx_desc_t    bd_writedata;
    logic        av_waitrequest;
    logic [`TXDMA_DATA_W-1:0] av_readdata;
    logic        av_readdatavalid;
    logic        av_read;
    logic [31:0] av_address;
    logic [7:0]  tx_data;
    logic        tx_dv, tx_sop, tx_eop, tx_ack;
    tx_stat_t    tx_stat;
    logic        tx_stat_valid, tx_retry;
    logic        per_packet_pad, per_packet_crc;
    logic        tx_underrun, txb_irq, txe_irq;

    // Models and scoreboard state
    tx_desc_t    desc_ram [1 << `TXDMA_IDX_W];
    logic [31:0] ptr_ram  [1 << `TXDMA_IDX_W];
    logic [31:0] rd_addr_q[$];                  // Accepted reads, in order
    int          rd_due_q[$];                   // Cycle each read may return
    logic [7:0]  rx_bytes[$];
    logic        rx_sop[$];
    logic        rx_eop[$];
    logic [`TXDMA_IDX_W-1:0] wb_index_q[$];
    tx_desc_t    wb_data_q[$];
    int          cycle = 0;
    int          stat_delay = 0;                // Countdown to MAC status
    int          retry_left = 0;
    int          txb_count = 0;
    int          txe_count = 0;
    int          fetch_count = 0;               // Ready descriptors fetched
    int          checks = 0;
    int          errors = 0;
    logic        stress = 1'b0;                 // Random ack and waitrequest
    logic        pad_seen, crc_seen;
    tx_stat_t    mac_status;
    int unsigned seed;

    txdma_top dut_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    assign bd_desc = desc_ram[bd_index];        // Combinational RAM
    assign bd_ptr  = ptr_ram[bd_index];

    // Little-endian frame buffer, every address bit matters
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {a[20:16], a[23:21]} ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
    endfunction

    //*********************************************************************
    // Memory model, decides the next edge at the falling edge
    always @(negedge clk) begin
        cycle++;
        av_waitrequest   = stress ? ($urandom_range(0, 2) == 0) : 1'b0;
        av_readdatavalid = 1'b0;
        if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
            av_readdatavalid = 1'b1;
            av_readdata      = mem_word(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
        end
        if (av_read && !av_waitrequest) begin   // Accepted on the coming edge
            rd_addr_q.push_back(av_address);
            rd_due_q.push_back(cycle + $urandom_range(1, 4));
        end
    end

    // MAC model
    always @(negedge clk) begin
        tx_stat_valid = 1'b0;
        if (stat_delay > 0) begin
            stat_delay--;
            if (stat_delay == 0) begin
                tx_stat_valid = 1'b1;
                tx_stat       = mac_status;
                tx_retry      = (retry_left > 0); // Level kept until next status
                if (retry_left > 0) retry_left--;
            end
        end
        tx_ack = stress ? ($urandom_range(0, 1) == 1) : 1'b1;
        #1;
        if (tx_dv && tx_ack) begin
            assert (!tx_underrun) else begin
                errors++;
                $display("%0t: byte acked with the FIFO empty (underrun)", $time);
            end
            if (!tx_underrun) begin
                rx_bytes.push_back(tx_data);
                rx_sop.push_back(tx_sop);
                rx_eop.push_back(tx_eop);
                if (tx_sop) begin
                    pad_seen = per_packet_pad;
                    crc_seen = per_packet_crc;
                end
                if (tx_eop) stat_delay = 4;
            end
        end
    end

    // Descriptor fetch, write-back and interrupt monitor
    always @(negedge clk) begin
        if (bd_read && !bd_wait && bd_desc.ready) fetch_count++;
        if (bd_write && !bd_wait) begin
            wb_index_q.push_back(bd_index);
            wb_data_q.push_back(bd_writedata);
            desc_ram[bd_index] = bd_writedata;
        end
        if (txb_irq) txb_count++;
        if (txe_irq) txe_count++;
    end

    //*********************************************************************
    // Check helpers
    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    // Bytes ptr .. ptr+len-1, markers on first and last only
    task automatic verify_frame(input int base, input logic [31:0] ptr, input int len);
        int i;
        expect_true(rx_bytes.size() >= base + len, "frame is shorter than its descriptor");
        if (rx_bytes.size() < base + len) return;
        for (i = 0; i < len; i++) begin
            expect_equal("tx_data", rx_bytes[base+i], mem_byte(ptr + i));
            expect_equal("tx_sop", rx_sop[base+i], i == 0);
            expect_equal("tx_eop", rx_eop[base+i], i == len - 1);
        end
    endtask

    // Strobes and requests stay quiet out of reset
    task automatic check_reset_outputs();
        expect_equal("bd_read", bd_read, 1'b0);
        expect_equal("bd_write", bd_write, 1'b0);
        expect_equal("av_read", av_read, 1'b0);
        expect_equal("tx_dv", tx_dv, 1'b0);
        expect_equal("txb_irq", txb_irq, 1'b0);
        expect_equal("txe_irq", txe_irq, 1'b0);
        expect_equal("tx_underrun", tx_underrun, 1'b0);
    endtask

    task automatic load_desc(input int idx, input int len, input logic [31:0] ptr,
                             input logic irq, input logic wrap, input logic pad,
                             input logic crc);
        tx_desc_t d;
        d       = '0;
        d.len   = len;
        d.ready = 1'b1;
        d.irq   = irq;
        d.wrap  = wrap;
        d.pad   = pad;
        d.crc   = crc;
        ptr_ram[idx]  = ptr;
        desc_ram[idx] = d;
    endtask

    // Disable, let the index fall to 0, clear RAM and scoreboard
    task automatic restart_ring(input int max_bd);
        tx_en = 1'b0;
        repeat (4) @(negedge clk);
        foreach (desc_ram[i]) desc_ram[i] = '0;
        max_tx_bd   = max_bd;
        mac_status  = '0;
        stress      = 1'b0;
        retry_left  = 0;
        txb_count   = 0;
        txe_count   = 0;
        fetch_count = 0;
        rx_bytes.delete();
        rx_sop.delete();
        rx_eop.delete();
        wb_index_q.delete();
        wb_data_q.delete();
    endtask

    task automatic wait_writebacks(input int n);
        while (wb_index_q.size() < n) @(negedge clk);
        repeat (3) @(negedge clk);              // Let the interrupt pulse land
    endtask

    //*********************************************************************
    // Directed tests
    task automatic aligned_frame();
        restart_ring(10);
        load_desc(0, 8, 32'h1000, 1'b0, 1'b0, 1'b1, 1'b0);
        tx_en = 1'b1;
        wait_writebacks(1);
        verify_frame(0, 32'h1000, 8);
        expect_equal("per_packet_pad", pad_seen, 1'b1);
        expect_equal("per_packet_crc", crc_seen, 1'b0);
    endtask

    task automatic unaligned_frame();
        restart_ring(10);
        load_desc(0, 13, 32'h2003, 1'b0, 1'b0, 1'b0, 1'b1);
        tx_en = 1'b1;
        wait_writebacks(1);
        verify_frame(0, 32'h2003, 13);
        expect_equal("per_packet_crc", crc_seen, 1'b1);
    endtask

    task automatic writeback_and_irq();
        tx_desc_t sent;
        tx_desc_t exp;
        restart_ring(10);
        load_desc(0, 16, 32'h3000, 1'b1, 1'b0, 1'b1, 1'b1);
        desc_ram[0].rsvd = 2'b10;               // Must survive write-back
        desc_ram[0].stat = 9'h1ff;              // Old status gets replaced
        sent = desc_ram[0];
        mac_status.retry_cnt = 4'd3;            // Clean, retries only
        tx_en = 1'b1;
        wait_writebacks(1);
        exp       = sent;
        exp.ready = 1'b0;
        exp.stat  = mac_status;
        expect_equal("bd_writedata", wb_data_q[0], exp);
        expect_equal("txb_irq pulses", txb_count, 1);
        expect_equal("txe_irq pulses", txe_count, 0);
        verify_frame(0, 32'h3000, 16);
        mac_status    = '0;
        mac_status.lc = 1'b1;                   // Late collision
        load_desc(1, 16, 32'h3102, 1'b1, 1'b0, 1'b0, 1'b0);
        sent = desc_ram[1];
        wait_writebacks(2);
        exp       = sent;
        exp.ready = 1'b0;
        exp.stat  = mac_status;
        expect_equal("bd_writedata", wb_data_q[1], exp);
        expect_equal("bd_index", wb_index_q[1], 1);
        expect_equal("txb_irq pulses", txb_count, 1);
        expect_equal("txe_irq pulses", txe_count, 1);
        verify_frame(16, 32'h3102, 16);
    endtask

    task automatic ring_walk();
        int i;
        restart_ring(2);
        for (i = 0; i < 3; i++) begin
            load_desc(i, 8, 32'h4000 + i * 32'h100, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        tx_en = 1'b1;
        wait_writebacks(3);
        for (i = 0; i < 3; i++) begin
            expect_equal("bd_index", wb_index_q[i], i);
            verify_frame(i * 8, 32'h4000 + i * 32'h100, 8);
        end
        expect_equal("bd_index", bd_index, 0);  // Past max_tx_bd
        restart_ring(10);
        load_desc(0, 4, 32'h4300, 1'b0, 1'b0, 1'b0, 1'b0);
        load_desc(1, 4, 32'h4404, 1'b0, 1'b1, 1'b0, 1'b0);
        load_desc(2, 4, 32'h4500, 1'b0, 1'b0, 1'b0, 1'b0);  // Only reached if wrap fails
        tx_en = 1'b1;
        wait_writebacks(2);
        repeat (6) @(negedge clk);
        expect_equal("bd_index", bd_index, 0);
        expect_equal("write-backs", wb_index_q.size(), 2);
        verify_frame(0, 32'h4300, 4);
        verify_frame(4, 32'h4404, 4);
    endtask

    task automatic long_frame_stress();
        restart_ring(10);
        stress = 1'b1;
        load_desc(0, 200, 32'h5002, 1'b0, 1'b0, 1'b0, 1'b0);
        tx_en = 1'b1;
        wait_writebacks(1);
        stress = 1'b0;
        expect_equal("frame bytes", rx_bytes.size(), 200);
        verify_frame(0, 32'h5002, 200);
    endtask

    task automatic retry_frame();
        restart_ring(10);
        retry_left = 1;
        load_desc(0, 20, 32'h6000, 1'b1, 1'b0, 1'b0, 1'b0);
        tx_en = 1'b1;
        wait_writebacks(1);
        repeat (10) @(negedge clk);
        expect_equal("write-backs", wb_index_q.size(), 1);
        expect_equal("ready fetches", fetch_count, 2);  // Same descriptor fetched twice
        expect_equal("frame bytes", rx_bytes.size(), 40);
        verify_frame(0, 32'h6000, 20);
        verify_frame(20, 32'h6000, 20);         // Same buffer sent again
        expect_equal("txb_irq pulses", txb_count, 1);
    endtask

    //*********************************************************************
    // Main sequence
    initial begin
        seed             = 32'hf568_3825;
        void'($urandom(seed));
        reset            = 1'b1;
        tx_en            = 1'b0;
        max_tx_bd        = 10;
        bd_wait          = 1'b0;
        av_waitrequest   = 1'b0;
        av_readdata      = '0;
        av_readdatavalid = 1'b0;
        tx_ack           = 1'b0;
        tx_stat          = '0;
        tx_stat_valid    = 1'b0;
        tx_retry         = 1'b0;
        mac_status       = '0;
        pad_seen         = 1'b0;
        crc_seen         = 1'b0;
        foreach (desc_ram[i]) begin
            desc_ram[i] = '0;
            ptr_ram[i]  = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        check_reset_outputs();
        aligned_frame();
        unaligned_frame();
        writeback_and_irq();
        ring_walk();
        long_frame_stress();
        retry_frame();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a test is stuck", WD_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/txdma_pkg.sv
hw/txdma_word_fifo.sv
hw/txdma_desc_ctrl.sv
hw/txdma_mem_reader.sv
hw/txdma_byte_streamer.sv
hw/txdma_top.sv
verification/tb_txdma.sv

// ==== Bender.yml ====
package:
  name: txdma

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/txdma_pkg.sv
      - hw/txdma_word_fifo.sv
      - hw/txdma_desc_ctrl.sv
      - hw/txdma_mem_reader.sv
      - hw/txdma_byte_streamer.sv
      - hw/txdma_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_txdma.sv
